// File: pcxt_pkg.sv
/*
 * PC/XT glue package
 * Clock rates, reset and splash timing, OSD status bit map,
 * keyboard DIP switch values and the shared data types
 */

package pcxt_pkg;

	////////////////////
	// Clock and rates
	////////////////////

	// Board oscillator
	localparam logic [31:0] CLK_HZ = 32'd50_000_000;
	// Audio sample rate for the mixer
	localparam logic [31:0] AUDIO_RATE_HZ = 32'd44_100;

	////////////////////
	// Reset timing
	////////////////////

	// Hold time after the last reset request
	localparam logic [15:0] RESET_STRETCH = 16'd65_535;
	// Extra cycles before the CPU leaves reset
	localparam logic [15:0] CPU_RESET_DELAY = 16'd42;

	// Splash screen length
	localparam logic [3:0] SPLASH_SECONDS = 4'd5;
	// One second of system clock
	localparam logic [31:0] SPLASH_SECOND_TICKS_DEF = CLK_HZ;
	// Roughly 90 ms of LED afterglow
	localparam logic [31:0] LED_HOLD_TICKS_DEF = 32'd4_500_000;

	// XT switch block, MDA or CGA 80 columns
	localparam logic [7:0] DIP_MDA = 8'h3D;
	localparam logic [7:0] DIP_CGA = 8'h2D;

	////////////////////
	// OSD status bits
	////////////////////

	localparam int ST_RESET        = 0;
	localparam int ST_TANDY        = 3;
	localparam int ST_MDA          = 4;
	// Two bits, green / amber / white
	localparam int ST_MDA_RGB_LO   = 5;
	// Splash skip, same bit also plugs the DSS/Covox
	localparam int ST_SPLASH_SKIP  = 7;
	localparam int ST_ASPECT_LO    = 8;
	localparam int ST_ADLIB_HIDE   = 10;
	localparam int ST_EMS_OFF      = 11;
	localparam int ST_EMS_FRAME_LO = 12;
	// Three bits of display color mode
	localparam int ST_MONO_LO      = 14;

	typedef logic [31:0] status_t;
	typedef logic [12:0] aspect_t;

	// Port C sees one nibble of the switch byte at a time
	typedef union packed {
		logic [7:0] whole;
		struct packed {
			logic [3:0] hi;
			logic [3:0] lo;
		} nib;
	} dip_switch_t;

endpackage

// File: reset_sequencer.sv
/*
 * Reset sequencer
 * Collects OSD, button and splash reset requests, stretches them
 * into the system reset and releases the CPU reset a fixed number
 * of cycles after the system reset drops
 */

`timescale 1ns/1ps

module reset_sequencer (
	input  logic              CLK_50M,
	input  logic              reset_wire,
	input  pcxt_pkg::status_t status,
	input  logic              user_button,
	input  logic              restart_req,
	output logic              sys_reset,
	output logic              cpu_reset
);

	logic        reset_req;
	logic [15:0] stretch_cnt;
	logic [15:0] cpu_cnt;

	// Any source restarts the machine
	assign reset_req = status[pcxt_pkg::ST_RESET] | user_button | restart_req;

	////////////////////
	// System reset
	////////////////////

	// Reloaded on every request cycle
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			stretch_cnt <= pcxt_pkg::RESET_STRETCH;
		end else if (reset_req) begin
			stretch_cnt <= pcxt_pkg::RESET_STRETCH;
		end else if (stretch_cnt != 16'd0) begin
			stretch_cnt <= stretch_cnt - 16'd1;
		end
	end

	// Request shows up in the same cycle
	assign sys_reset = reset_req | (stretch_cnt != 16'd0);

	////////////////////
	// CPU reset
	////////////////////

	// Held at full delay while the system is in reset,
	// counts out once the system reset is gone
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_cnt <= pcxt_pkg::CPU_RESET_DELAY + 16'd1;
		end else if (sys_reset) begin
			cpu_cnt <= pcxt_pkg::CPU_RESET_DELAY + 16'd1;
		end else if (cpu_cnt != 16'd0) begin
			cpu_cnt <= cpu_cnt - 16'd1;
		end
	end

	// Never lower than the system reset
	assign cpu_reset = sys_reset | (cpu_cnt != 16'd0);

endmodule

// File: splash_timer.sv
/*
 * Splash screen timer
 * Keeps the machine in reset while the splash is shown, until the
 * OSD skip bit is set or the programmed number of seconds runs out
 */

`timescale 1ns/1ps

module splash_timer #(
	parameter logic [31:0] SECOND_TICKS = pcxt_pkg::SPLASH_SECOND_TICKS_DEF
) (
	input  logic              CLK_50M,
	input  logic              reset_wire,
	input  pcxt_pkg::status_t status,
	output logic              splash_active
);

	logic [31:0] tick_cnt;
	logic [3:0]  sec_cnt;
	logic        sec_wrap;

	// Last cycle of the current second
	assign sec_wrap = (tick_cnt == SECOND_TICKS - 32'd1);

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			tick_cnt      <= 32'd0;
			sec_cnt       <= 4'd0;
			splash_active <= 1'b1;
		end else if (splash_active) begin
			if (status[pcxt_pkg::ST_SPLASH_SKIP]) begin
				// User turned the splash off
				splash_active <= 1'b0;
			end else if (sec_wrap) begin
				tick_cnt <= 32'd0;
				sec_cnt  <= sec_cnt + 4'd1;
				// Final second done
				if (sec_cnt == pcxt_pkg::SPLASH_SECONDS - 4'd1)
					splash_active <= 1'b0;
			end else begin
				tick_cnt <= tick_cnt + 32'd1;
			end
		end
	end

endmodule

// File: audio_tick_gen.sv
/*
 * Audio sample clock enable
 * Fractional phase accumulator giving a 44.1 kHz enable on average
 * from the 50 MHz system clock, one cycle wide
 */

`timescale 1ns/1ps

module audio_tick_gen (
	input  logic CLK_50M,
	input  logic reset_wire,
	output logic cen_44100
);

	logic [31:0] phase;
	logic [31:0] phase_next;

	// Add one sample period worth of phase per clock
	assign phase_next = phase + pcxt_pkg::AUDIO_RATE_HZ;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			phase     <= 32'd0;
			cen_44100 <= 1'b0;
		end else if (phase_next >= pcxt_pkg::CLK_HZ) begin
			// Wrap keeps the remainder, no drift
			phase     <= phase_next - pcxt_pkg::CLK_HZ;
			cen_44100 <= 1'b1;
		end else begin
			phase     <= phase_next;
			cen_44100 <= 1'b0;
		end
	end

endmodule

// File: config_decoder.sv
/*
 * OSD configuration decoder
 * Splits the status word into video, model, audio and EMS options
 * and builds the keyboard port C switch nibble
 */

`timescale 1ns/1ps

module config_decoder (
	input  pcxt_pkg::status_t status,
	input  logic              port_b_sel,
	output pcxt_pkg::aspect_t video_arx,
	output pcxt_pkg::aspect_t video_ary,
	output logic              tandy_mode,
	output logic              mda_mode,
	output logic [1:0]        mda_rgb,
	output logic [2:0]        mono_mode,
	output logic              adlib_hide,
	output logic              covox_en,
	output logic              ems_enabled,
	output logic [1:0]        ems_frame,
	output logic [3:0]        port_c_low
);

	logic [1:0]            aspect_sel;
	pcxt_pkg::dip_switch_t dip_sw;

	////////////////////
	// Video
	////////////////////

	assign aspect_sel = status[pcxt_pkg::ST_ASPECT_LO +: 2];

	// Original is 4:3, other values pick a scaler preset
	always_comb begin
		if (aspect_sel == 2'd0) begin
			video_arx = 13'd4;
			video_ary = 13'd3;
		end else begin
			video_arx = {11'd0, aspect_sel} - 13'd1;
			video_ary = 13'd0;
		end
	end

	assign mda_mode   = status[pcxt_pkg::ST_MDA];
	assign mda_rgb    = status[pcxt_pkg::ST_MDA_RGB_LO +: 2];
	assign mono_mode  = status[pcxt_pkg::ST_MONO_LO +: 3];
	assign tandy_mode = status[pcxt_pkg::ST_TANDY];

	// Audio and memory options
	assign adlib_hide  = status[pcxt_pkg::ST_ADLIB_HIDE];
	// Shares its bit with the splash skip
	assign covox_en    = status[pcxt_pkg::ST_SPLASH_SKIP];
	assign ems_enabled = ~status[pcxt_pkg::ST_EMS_OFF];
	assign ems_frame   = status[pcxt_pkg::ST_EMS_FRAME_LO +: 2];

	////////////////////
	// DIP switches
	////////////////////

	// Switch byte follows the video card in use
	always_comb begin
		dip_sw.whole = mda_mode ? pcxt_pkg::DIP_MDA : pcxt_pkg::DIP_CGA;
		// PB3 selects which half the BIOS reads
		port_c_low = port_b_sel ? dip_sw.nib.hi : dip_sw.nib.lo;
	end

endmodule

// File: sd_spi_router.sv
/*
 * SD SPI router
 * Remembers whether a disk image is mounted and steers the SPI
 * master either to the physical SD card or to the virtual card
 */

`timescale 1ns/1ps

module sd_spi_router (
	input  logic        CLK_50M,
	input  logic        reset_wire,
	input  logic        img_mounted,
	input  logic [63:0] img_size,
	input  logic        spi_cs,
	input  logic        spi_sck,
	input  logic        spi_mosi,
	input  logic        sd_miso,
	input  logic        vsd_miso,
	output logic        spi_miso,
	output logic        sd_cs,
	output logic        sd_sck,
	output logic        sd_mosi,
	output logic        vsd_cs
);

	logic vsd_active;

	// Nonzero image size means the virtual card takes over
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire)
			vsd_active <= 1'b0;
		else if (img_mounted)
			vsd_active <= |img_size;
	end

	// Physical card parked deselected with idle lines
	assign sd_cs   = spi_cs | vsd_active;
	assign sd_sck  = spi_sck & ~vsd_active;
	assign sd_mosi = spi_mosi & ~vsd_active;

	// Virtual card only selected when an image is present
	assign vsd_cs = spi_cs | ~vsd_active;

	// Read data from whichever card is selected
	assign spi_miso = vsd_active ? vsd_miso : sd_miso;

endmodule

// File: activity_led.sv
/*
 * Activity LED stretcher
 * Turns short disk activity pulses into an LED level long enough
 * to be seen
 */

`timescale 1ns/1ps

module activity_led #(
	parameter logic [31:0] HOLD_TICKS = pcxt_pkg::LED_HOLD_TICKS_DEF
) (
	input  logic CLK_50M,
	input  logic reset_wire,
	input  logic activity,
	output logic led_user
);

	logic [31:0] hold_cnt;

	// Each pulse restarts the full hold time
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire)
			hold_cnt <= 32'd0;
		else if (activity)
			hold_cnt <= HOLD_TICKS;
		else if (hold_cnt != 32'd0)
			hold_cnt <= hold_cnt - 32'd1;
	end

	assign led_user = (hold_cnt != 32'd0);

endmodule

// File: pcxt_glue_top.sv
/*
 * PC/XT system glue top level
 * Reset sequencing, splash timing, audio clock enable, OSD option
 * decoding, SD card routing and the activity LED around the core
 */

`timescale 1ns/1ps

module pcxt_glue_top #(
	parameter logic [31:0] SPLASH_SECOND_TICKS = pcxt_pkg::SPLASH_SECOND_TICKS_DEF,
	parameter logic [31:0] LED_HOLD_TICKS      = pcxt_pkg::LED_HOLD_TICKS_DEF
) (
	input  logic              CLK_50M,
	input  logic              reset_wire,
	input  pcxt_pkg::status_t status,
	input  logic              user_button,
	input  logic              img_mounted,
	input  logic [63:0]       img_size,
	input  logic              spi_cs,
	input  logic              spi_sck,
	input  logic              spi_mosi,
	input  logic              sd_miso,
	input  logic              vsd_miso,
	input  logic              port_b_sel,
	input  logic              disk_activity,
	output logic              sys_reset,
	output logic              cpu_reset,
	output logic              splash_active,
	output logic              cen_44100,
	output pcxt_pkg::aspect_t video_arx,
	output pcxt_pkg::aspect_t video_ary,
	output logic              tandy_mode,
	output logic              mda_mode,
	output logic [1:0]        mda_rgb,
	output logic [2:0]        mono_mode,
	output logic              adlib_hide,
	output logic              covox_en,
	output logic              ems_enabled,
	output logic [1:0]        ems_frame,
	output logic [3:0]        port_c_low,
	output logic              spi_miso,
	output logic              sd_cs,
	output logic              sd_sck,
	output logic              sd_mosi,
	output logic              vsd_cs,
	output logic              vsd_sck,
	output logic              vsd_mosi,
	output logic              led_user
);

	////////////////////
	// Reset path
	////////////////////

	// Splash holds the machine in reset through restart_req
	splash_timer #(
		.SECOND_TICKS(SPLASH_SECOND_TICKS)
	) u_splash (
		.CLK_50M      (CLK_50M),
		.reset_wire   (reset_wire),
		.status       (status),
		.splash_active(splash_active)
	);

	reset_sequencer u_reset (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.status     (status),
		.user_button(user_button),
		.restart_req(splash_active),
		.sys_reset  (sys_reset),
		.cpu_reset  (cpu_reset)
	);

	////////////////////
	// Audio and options
	////////////////////

	audio_tick_gen u_audio (
		.CLK_50M   (CLK_50M),
		.reset_wire(reset_wire),
		.cen_44100 (cen_44100)
	);

	config_decoder u_config (
		.status     (status),
		.port_b_sel (port_b_sel),
		.video_arx  (video_arx),
		.video_ary  (video_ary),
		.tandy_mode (tandy_mode),
		.mda_mode   (mda_mode),
		.mda_rgb    (mda_rgb),
		.mono_mode  (mono_mode),
		.adlib_hide (adlib_hide),
		.covox_en   (covox_en),
		.ems_enabled(ems_enabled),
		.ems_frame  (ems_frame),
		.port_c_low (port_c_low)
	);

	////////////////////
	// SD card and LED
	////////////////////

	sd_spi_router u_sd (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.img_mounted(img_mounted),
		.img_size   (img_size),
		.spi_cs     (spi_cs),
		.spi_sck    (spi_sck),
		.spi_mosi   (spi_mosi),
		.sd_miso    (sd_miso),
		.vsd_miso   (vsd_miso),
		.spi_miso   (spi_miso),
		.sd_cs      (sd_cs),
		.sd_sck     (sd_sck),
		.sd_mosi    (sd_mosi),
		.vsd_cs     (vsd_cs)
	);

	// Virtual card shares clock and data with the master
	assign vsd_sck  = spi_sck;
	assign vsd_mosi = spi_mosi;

	activity_led #(
		.HOLD_TICKS(LED_HOLD_TICKS)
	) u_led (
		.CLK_50M   (CLK_50M),
		.reset_wire(reset_wire),
		.activity  (disk_activity),
		.led_user  (led_user)
	);

endmodule

// File: pcxt_glue_checker.sv
/*
 * PC/XT glue checker
 * Bound to the top level, watches the audio enable width, the
 * reset ordering and the SD card parking after a mount
 */

`timescale 1ns/1ps

module pcxt_glue_checker (
	input logic        CLK_50M,
	input logic        reset_wire,
	input logic        cen_44100,
	input logic        sys_reset,
	input logic        cpu_reset,
	input logic        img_mounted,
	input logic [63:0] img_size,
	input logic        sd_cs,
	input logic        vsd_cs
);

	// Read back by the testbench at the end of the run
	int assert_failures = 0;

	// Enable never lasts two cycles
	a_cen_single: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		cen_44100 |=> !cen_44100)
		else begin
			assert_failures++;
			$error("cen_44100 high on two consecutive cycles");
		end

	// CPU reset covers the system reset and outlasts it
	a_cpu_covers_sys: assert property (@(posedge CLK_50M)
		sys_reset |-> cpu_reset ##1 cpu_reset)
		else begin
			assert_failures++;
			$error("cpu_reset low while or right after sys_reset high");
		end

	// Mount register parks the card that is not in use
	a_one_card: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		img_mounted |=> ($past(img_size) != 64'd0 ? sd_cs : vsd_cs))
		else begin
			assert_failures++;
			$error("card not parked after an image mount");
		end

endmodule

bind pcxt_glue_top pcxt_glue_checker u_checker (.*);

// File: pcxt_glue_tb.sv
/*
 * PC/XT glue testbench
 * Splash and reset release, user restart, audio enable rate,
 * option decoding table, SD card routing and the activity LED
 */

`timescale 1ns/1ps

module pcxt_glue_tb;

	localparam int SIG_SYS_RESET  = 0;
	localparam int SIG_CPU_RESET  = 1;
	localparam int SIG_LED        = 2;
	localparam int SIG_AUDIO_DONE = 3;
	// Splash second and LED hold used for this run
	localparam int SECOND_TICKS   = 20;
	localparam int HOLD_TICKS     = 50;
	localparam int AUDIO_WINDOW   = 100_000;
	localparam int TABLE_ROWS     = 6;

	logic              CLK_50M;
	logic              reset_wire;
	pcxt_pkg::status_t status;
	logic              user_button;
	logic              img_mounted;
	logic [63:0]       img_size;
	logic              spi_cs;
	logic              spi_sck;
	logic              spi_mosi;
	logic              sd_miso;
	logic              vsd_miso;
	logic              port_b_sel;
	logic              disk_activity;
	logic              sys_reset;
	logic              cpu_reset;
	logic              splash_active;
	logic              cen_44100;
	pcxt_pkg::aspect_t video_arx;
	pcxt_pkg::aspect_t video_ary;
	logic              tandy_mode;
	logic              mda_mode;
	logic [1:0]        mda_rgb;
	logic [2:0]        mono_mode;
	logic              adlib_hide;
	logic              covox_en;
	logic              ems_enabled;
	logic [1:0]        ems_frame;
	logic [3:0]        port_c_low;
	logic              spi_miso;
	logic              sd_cs;
	logic              sd_sck;
	logic              sd_mosi;
	logic              vsd_cs;
	logic              vsd_sck;
	logic              vsd_mosi;
	logic              led_user;

	integer      seed = 32'h7170_e083;
	int          audio_pulses;
	logic        audio_done;
	// aspect[37:36] mda[35] pb_sel[34] ems_off[33] frame[32:31]
	// exp_arx[30:18] exp_ary[17:5] exp_nibble[4:1] exp_ems_en[0]
	logic [37:0] config_table [0:TABLE_ROWS-1];

	pcxt_glue_top #(
		.SPLASH_SECOND_TICKS(SECOND_TICKS),
		.LED_HOLD_TICKS     (HOLD_TICKS)
	) dut (.*);

	// 50 MHz board clock
	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic stop_with_failure();
		$display("Simulation FAILED");
		$fatal(1, "Testbench stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_nibble(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_aspect(input string name, input pcxt_pkg::aspect_t got,
			input pcxt_pkg::aspect_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	// Cycle counts with a tolerance window
	task automatic check_count(input string name, input int got, input int lo, input int hi);
		if (got < lo || got > hi) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h to 0x%h", name, got, lo, hi);
			stop_with_failure();
		end
	endtask

	function automatic logic signal_level(input int sel);
		case (sel)
			SIG_SYS_RESET: return sys_reset;
			SIG_CPU_RESET: return cpu_reset;
			SIG_LED:       return led_user;
			default:       return audio_done;
		endcase
	endfunction

	// Counts falling edges until the level shows up
	task automatic wait_for_level(input string name, input int sel, input logic level,
			input int limit, output int cycles);
		cycles = 0;
		while (signal_level(sel) !== level) begin
			if (cycles >= limit) begin
				$display("Timeout: %s did not reach %0d within %0d cycles", name, level, limit);
				stop_with_failure();
			end else begin
				@(negedge CLK_50M);
				cycles++;
			end
		end
	endtask

	task automatic load_config_table();
		config_table[0] = {2'd0, 1'b0, 1'b0, 1'b0, 2'd0, 13'd4, 13'd3, 4'hD, 1'b1};
		config_table[1] = {2'd1, 1'b0, 1'b1, 1'b0, 2'd1, 13'd0, 13'd0, 4'h2, 1'b1};
		config_table[2] = {2'd2, 1'b1, 1'b0, 1'b1, 2'd2, 13'd1, 13'd0, 4'hD, 1'b0};
		config_table[3] = {2'd3, 1'b1, 1'b1, 1'b0, 2'd3, 13'd2, 13'd0, 4'h3, 1'b1};
		config_table[4] = {2'd0, 1'b1, 1'b1, 1'b1, 2'd0, 13'd4, 13'd3, 4'h3, 1'b0};
		config_table[5] = {2'd2, 1'b0, 1'b0, 1'b0, 2'd3, 13'd1, 13'd0, 4'hD, 1'b1};
	endtask

	// Audio enables over a fixed window after reset
	initial begin
		audio_pulses = 0;
		audio_done   = 1'b0;
		@(negedge reset_wire);
		for (int i = 0; i < AUDIO_WINDOW; i++) begin
			@(negedge CLK_50M);
			if (cen_44100)
				audio_pulses++;
		end
		audio_done = 1'b1;
	end

	////////////////////
	// Main sequence
	////////////////////

	initial begin : main_seq
		int                cycles;
		int                exp_cycles;
		pcxt_pkg::status_t st;
		logic [37:0]       row;

		reset_wire    = 1'b1;
		status        = '0;
		user_button   = 1'b0;
		img_mounted   = 1'b0;
		img_size      = 64'd0;
		spi_cs        = 1'b1;
		spi_sck       = 1'b0;
		spi_mosi      = 1'b0;
		sd_miso       = 1'b0;
		vsd_miso      = 1'b0;
		port_b_sel    = 1'b0;
		disk_activity = 1'b0;
		load_config_table();

		repeat (5) @(posedge CLK_50M);
		reset_wire <= 1'b0;
		@(negedge CLK_50M);

		// Splash runs out, then the stretch
		exp_cycles = int'(pcxt_pkg::SPLASH_SECONDS) * SECOND_TICKS
			+ int'(pcxt_pkg::RESET_STRETCH);
		wait_for_level("sys_reset", SIG_SYS_RESET, 1'b0, exp_cycles + 10, cycles);
		check_count("sys_reset release", cycles, exp_cycles - 2, exp_cycles + 2);
		check_bit("splash_active", splash_active, 1'b0);
		exp_cycles = int'(pcxt_pkg::CPU_RESET_DELAY) + 1;
		wait_for_level("cpu_reset", SIG_CPU_RESET, 1'b0, exp_cycles + 10, cycles);
		check_count("cpu_reset delay", cycles, exp_cycles, exp_cycles);

		// One cycle button press
		@(posedge CLK_50M);
		user_button <= 1'b1;
		@(negedge CLK_50M);
		check_bit("sys_reset", sys_reset, 1'b1);
		check_bit("cpu_reset", cpu_reset, 1'b1);
		@(posedge CLK_50M);
		user_button <= 1'b0;
		@(negedge CLK_50M);
		exp_cycles = int'(pcxt_pkg::RESET_STRETCH);
		wait_for_level("sys_reset", SIG_SYS_RESET, 1'b0, exp_cycles + 10, cycles);
		check_count("sys_reset restart", cycles, exp_cycles - 2, exp_cycles + 2);
		exp_cycles = int'(pcxt_pkg::CPU_RESET_DELAY) + 1;
		wait_for_level("cpu_reset", SIG_CPU_RESET, 1'b0, exp_cycles + 10, cycles);
		check_count("cpu_reset restart delay", cycles, exp_cycles, exp_cycles);
		check_bit("splash_active", splash_active, 1'b0);

		// floor(N * rate / clock)
		wait_for_level("audio window", SIG_AUDIO_DONE, 1'b1, AUDIO_WINDOW, cycles);
		exp_cycles = int'(longint'(AUDIO_WINDOW) * longint'(pcxt_pkg::AUDIO_RATE_HZ)
			/ longint'(pcxt_pkg::CLK_HZ));
		check_count("cen_44100 pulses", audio_pulses, exp_cycles, exp_cycles);

		////////////////////
		// Option table
		////////////////////

		for (int r = 0; r < TABLE_ROWS; r++) begin
			row = config_table[r];
			// Random padding, reset bit kept clear
			st = $random(seed);
			st[pcxt_pkg::ST_RESET] = 1'b0;
			st[pcxt_pkg::ST_ASPECT_LO +: 2] = row[37:36];
			st[pcxt_pkg::ST_MDA] = row[35];
			st[pcxt_pkg::ST_EMS_OFF] = row[33];
			st[pcxt_pkg::ST_EMS_FRAME_LO +: 2] = row[32:31];
			@(posedge CLK_50M);
			status     <= st;
			port_b_sel <= row[34];
			@(negedge CLK_50M);
			check_aspect("video_arx", video_arx, row[30:18]);
			check_aspect("video_ary", video_ary, row[17:5]);
			check_nibble("port_c_low", port_c_low, row[4:1]);
			check_bit("ems_enabled", ems_enabled, row[0]);
			check_nibble("ems_frame", {2'b00, ems_frame}, {2'b00, row[32:31]});
			check_bit("mda_mode", mda_mode, row[35]);
			check_bit("covox_en", covox_en, st[pcxt_pkg::ST_SPLASH_SKIP]);
			// Plain option bits from the padding
			check_bit("tandy_mode", tandy_mode, st[pcxt_pkg::ST_TANDY]);
			check_bit("adlib_hide", adlib_hide, st[pcxt_pkg::ST_ADLIB_HIDE]);
			check_nibble("mda_rgb", {2'b00, mda_rgb}, {2'b00, st[pcxt_pkg::ST_MDA_RGB_LO +: 2]});
			check_nibble("mono_mode", {1'b0, mono_mode}, {1'b0, st[pcxt_pkg::ST_MONO_LO +: 3]});
		end
		@(posedge CLK_50M);
		status <= '0;

		////////////////////
		// SD routing
		////////////////////

		// Physical card after reset
		spi_cs   <= 1'b0;
		spi_sck  <= 1'b1;
		spi_mosi <= 1'b1;
		sd_miso  <= 1'b1;
		vsd_miso <= 1'b0;
		@(negedge CLK_50M);
		check_bit("sd_cs", sd_cs, 1'b0);
		check_bit("vsd_cs", vsd_cs, 1'b1);
		check_bit("sd_sck", sd_sck, 1'b1);
		check_bit("sd_mosi", sd_mosi, 1'b1);
		check_bit("spi_miso", spi_miso, 1'b1);

		@(posedge CLK_50M);
		img_mounted <= 1'b1;
		img_size    <= 64'h0000_0000_0010_0000;
		@(posedge CLK_50M);
		img_mounted <= 1'b0;
		@(negedge CLK_50M);
		check_bit("vsd_cs", vsd_cs, 1'b0);
		check_bit("sd_cs", sd_cs, 1'b1);
		check_bit("sd_sck", sd_sck, 1'b0);
		check_bit("sd_mosi", sd_mosi, 1'b0);
		check_bit("vsd_sck", vsd_sck, 1'b1);
		check_bit("vsd_mosi", vsd_mosi, 1'b1);
		check_bit("spi_miso", spi_miso, 1'b0);
		@(posedge CLK_50M);
		vsd_miso <= 1'b1;
		sd_miso  <= 1'b0;
		@(negedge CLK_50M);
		check_bit("spi_miso", spi_miso, 1'b1);

		// Empty image hands the bus back
		@(posedge CLK_50M);
		img_mounted <= 1'b1;
		img_size    <= 64'd0;
		@(posedge CLK_50M);
		img_mounted <= 1'b0;
		@(negedge CLK_50M);
		check_bit("sd_cs", sd_cs, 1'b0);
		check_bit("vsd_cs", vsd_cs, 1'b1);
		check_bit("spi_miso", spi_miso, 1'b0);

		// Single activity pulse
		@(posedge CLK_50M);
		disk_activity <= 1'b1;
		@(posedge CLK_50M);
		disk_activity <= 1'b0;
		@(negedge CLK_50M);
		check_bit("led_user", led_user, 1'b1);
		wait_for_level("led_user", SIG_LED, 1'b0, HOLD_TICKS + 10, cycles);
		check_count("led_user hold", cycles, HOLD_TICKS - 1, HOLD_TICKS + 1);

		if (dut.u_checker.assert_failures != 0) begin
			$display("Bound checker saw %0d assertion failures", dut.u_checker.assert_failures);
			stop_with_failure();
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

// File: compile.f
pcxt_pkg.sv
reset_sequencer.sv
splash_timer.sv
audio_tick_gen.sv
config_decoder.sv
sd_spi_router.sv
activity_led.sv
pcxt_glue_top.sv
pcxt_glue_checker.sv
pcxt_glue_tb.sv
